// File: verilog/preamp_adc_pkg.sv
`default_nettype none

package preamp_adc_pkg;

	////////////////////////////////////////
	// serial link and sample widths
	////////////////////////////////////////

	// clk50mhz cycles per half serial clock
	localparam int SPI_HALF = 2;
	// preamp gain word, both channels
	localparam int AMP_BITS = 8;
	// one adc channel
	localparam int ADC_BITS = 14;
	// serial clocks per conversion
	localparam int ADC_FRAME_BITS = 34;
	// sample interval counter
	localparam int CNT_BITS = 16;

	// gain codes, index is sw[1:0]
	localparam logic [3:0][3:0] GAIN_TABLE = {4'd4, 4'd3, 4'd2, 4'd1};

	// interval minus one, index is sw[3:2]
	localparam logic [3:0][CNT_BITS-1:0] INTERVAL_TABLE = {
		16'd1599, 16'd799, 16'd399, 16'd199
	};

	// worst case wait for an open frame, trigger to done plus margin
	localparam logic [CNT_BITS-1:0] FRAME_GUARD = CNT_BITS'(ADC_FRAME_BITS * 2 * SPI_HALF + 8);

	// control fsm states
	localparam logic [1:0] CTRL_IDLE = 2'd0;
	localparam logic [1:0] CTRL_WAIT_FRAME = 2'd1;
	localparam logic [1:0] CTRL_PROGRAM = 2'd2;
	localparam logic [1:0] CTRL_RUN = 2'd3;

	// one adc frame, shifted in raw then read by field
	typedef union packed {
		logic [ADC_FRAME_BITS-1:0] raw;
		struct packed {
			logic [1:0]          lead;
			logic [ADC_BITS-1:0] ch_a;
			logic [1:0]          mid;
			logic [ADC_BITS-1:0] ch_b;
			logic [1:0]          tail;
		} fld;
	} adc_frame_u;

endpackage

`default_nettype wire

// File: verilog/capture_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module capture_ctrl (
	input  logic        clk50mhz,
	input  logic        arst_n,
	input  logic [3:0]  sw,
	// preamp handshake
	output logic        amp_trig,
	output logic [3:0]  amp_a,
	output logic [3:0]  amp_b,
	input  logic        amp_done,
	// sample timer
	output logic        cnt_en,
	output logic [15:0] cnt_max,
	// adc results
	input  logic        adc_done,
	input  logic [13:0] adc_a,
	input  logic [13:0] adc_b,
	// user side
	output logic [7:0]  led,
	output logic [13:0] sample_a,
	output logic [13:0] sample_b,
	output logic        sample_valid
);

	logic [3:0]  sw_q;
	logic        sw_vld;
	logic [1:0]  gain_sel;
	logic [1:0]  intv_sel;
	logic [1:0]  state;
	logic [15:0] guard_cnt;
	logic        gain_chg;
	logic        intv_chg;
	logic        frame_clear;
	logic        start_prog;
	logic        start_run;

	// switch code differs from the one last sent
	assign gain_chg = sw_q[1:0] != gain_sel;
	assign intv_chg = sw_q[3:2] != intv_sel;

	// open frame finished, or none was ever started
	assign frame_clear = adc_done || (guard_cnt == preamp_adc_pkg::FRAME_GUARD);

	// first pass waits one cycle so sw_q holds real switch values
	assign start_prog = ((state == preamp_adc_pkg::CTRL_IDLE) && sw_vld) ||
		((state == preamp_adc_pkg::CTRL_WAIT_FRAME) && frame_clear && gain_chg);
	assign start_run = ((state == preamp_adc_pkg::CTRL_PROGRAM) && amp_done) ||
		((state == preamp_adc_pkg::CTRL_WAIT_FRAME) && frame_clear && !gain_chg);

	////////////////////////////////////////
	// sequencing fsm
	////////////////////////////////////////

	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			sw_q       <= 4'd0;
			sw_vld     <= 1'b0;
			gain_sel   <= 2'd0;
			intv_sel   <= 2'd0;
			state      <= preamp_adc_pkg::CTRL_IDLE;
			guard_cnt  <= 16'd0;
			amp_trig   <= 1'b0;
			cnt_en     <= 1'b0;
			cnt_max    <= 16'd0;
		end else begin
			sw_q     <= sw;
			sw_vld   <= 1'b1;
			amp_trig <= 1'b0;
			// stop the timer on any switch change, then drain
			if ((state == preamp_adc_pkg::CTRL_RUN) && (gain_chg || intv_chg)) begin
				cnt_en    <= 1'b0;
				guard_cnt <= 16'd0;
				state     <= preamp_adc_pkg::CTRL_WAIT_FRAME;
			end else if (state == preamp_adc_pkg::CTRL_WAIT_FRAME) begin
				guard_cnt <= guard_cnt + 16'd1;
			end
			if (start_prog) begin
				amp_trig   <= 1'b1;
				gain_sel   <= sw_q[1:0];
				state      <= preamp_adc_pkg::CTRL_PROGRAM;
			end
			// cnt_max loads while cnt_en is still low
			if (start_run) begin
				cnt_en   <= 1'b1;
				cnt_max  <= preamp_adc_pkg::INTERVAL_TABLE[sw_q[3:2]];
				intv_sel <= sw_q[3:2];
				state    <= preamp_adc_pkg::CTRL_RUN;
			end
		end
	end

	// same code on both preamp channels
	always_ff @(posedge clk50mhz) begin
		if (start_prog) begin
			amp_a <= preamp_adc_pkg::GAIN_TABLE[sw_q[1:0]];
			amp_b <= preamp_adc_pkg::GAIN_TABLE[sw_q[1:0]];
		end
	end

	////////////////////////////////////////
	// sample outputs
	////////////////////////////////////////

	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			led          <= 8'd0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= adc_done;
			if (adc_done)
				led <= adc_a[13:6];
		end
	end

	always_ff @(posedge clk50mhz) begin
		if (adc_done) begin
			sample_a <= adc_a;
			sample_b <= adc_b;
		end
	end

endmodule

`default_nettype wire

// File: verilog/amp_gain_spi.sv
`timescale 1ns/1ns
`default_nettype none

module amp_gain_spi (
	input  logic       clk50mhz,
	input  logic       arst_n,
	// handshake with control
	input  logic       amp_trig,
	input  logic [3:0] amp_a,
	input  logic [3:0] amp_b,
	output logic       amp_done,
	// preamp pins
	output logic       spi_sck,
	output logic       spi_mosi,
	output logic       amp_cs,
	output logic       amp_shdn,
	// readback not decoded
	input  logic       amp_dout
);

	logic       busy;
	logic       fin;
	logic [7:0] div_cnt;
	logic [3:0] bit_cnt;
	logic [preamp_adc_pkg::AMP_BITS-1:0] shreg;
	logic       half_end;
	logic       last_bit;

	// preamp kept powered
	assign amp_shdn = 1'b0;

	assign half_end = busy && (div_cnt == 8'(preamp_adc_pkg::SPI_HALF - 1));
	assign last_bit = bit_cnt == 4'(preamp_adc_pkg::AMP_BITS - 1);

	////////////////////////////////////////
	// serial clock and chip select
	////////////////////////////////////////

	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			fin      <= 1'b0;
			amp_done <= 1'b0;
			div_cnt  <= 8'd0;
			bit_cnt  <= 4'd0;
			spi_sck  <= 1'b0;
			spi_mosi <= 1'b0;
			amp_cs   <= 1'b1;
		end else begin
			fin      <= 1'b0;
			// done trails cs release by one cycle
			amp_done <= fin;
			if (!busy) begin
				if (amp_trig) begin
					busy     <= 1'b1;
					amp_cs   <= 1'b0;
					// msb out with cs low, sck still low
					spi_mosi <= amp_b[3];
					div_cnt  <= 8'd0;
					bit_cnt  <= 4'd0;
				end
			end else if (half_end) begin
				div_cnt <= 8'd0;
				if (!spi_sck) begin
					spi_sck <= 1'b1;
				end else begin
					spi_sck <= 1'b0;
					if (last_bit) begin
						busy     <= 1'b0;
						amp_cs   <= 1'b1;
						spi_mosi <= 1'b0;
						fin      <= 1'b1;
					end else begin
						bit_cnt  <= bit_cnt + 4'd1;
						// next bit on the falling edge
						spi_mosi <= shreg[preamp_adc_pkg::AMP_BITS-2];
					end
				end
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
		end
	end

	////////////////////////////////////////
	// gain word shifter
	////////////////////////////////////////

	// channel b in the upper nibble
	always_ff @(posedge clk50mhz) begin
		if (!busy && amp_trig)
			shreg <= {amp_b, amp_a};
		else if (half_end && spi_sck)
			shreg <= {shreg[preamp_adc_pkg::AMP_BITS-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// File: verilog/sample_timer.sv
`timescale 1ns/1ns
`default_nettype none

module sample_timer (
	input  logic        clk50mhz,
	input  logic        arst_n,
	input  logic        cnt_en,
	input  logic [15:0] cnt_max,
	output logic        cnt_trig
);

	logic [preamp_adc_pkg::CNT_BITS-1:0] cnt;
	logic wrap;

	// period is cnt_max + 1
	assign wrap = cnt == cnt_max;

	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			cnt      <= '0;
			cnt_trig <= 1'b0;
		end else if (!cnt_en) begin
			// restart from zero on every enable
			cnt      <= '0;
			cnt_trig <= 1'b0;
		end else if (wrap) begin
			cnt      <= '0;
			cnt_trig <= 1'b1;
		end else begin
			cnt      <= cnt + 1'b1;
			cnt_trig <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/adc_capture.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture (
	input  logic        clk50mhz,
	input  logic        arst_n,
	// from sample timer
	input  logic        adc_trig,
	// adc pins
	output logic        spi_sck,
	output logic        ad_conv,
	input  logic        adc_out,
	// results
	output logic        adc_done,
	output logic [13:0] adc_a,
	output logic [13:0] adc_b
);

	logic       busy;
	logic       fin;
	logic [7:0] div_cnt;
	logic [5:0] bit_cnt;
	logic       half_end;
	logic       last_clk;
	preamp_adc_pkg::adc_frame_u frame;

	// divider holds during the conversion strobe
	assign half_end = busy && !ad_conv &&
		(div_cnt == 8'(preamp_adc_pkg::SPI_HALF - 1));
	assign last_clk = bit_cnt == 6'(preamp_adc_pkg::ADC_FRAME_BITS - 1);

	////////////////////////////////////////
	// strobe, divider, clock count
	////////////////////////////////////////

	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			fin      <= 1'b0;
			adc_done <= 1'b0;
			ad_conv  <= 1'b0;
			spi_sck  <= 1'b0;
			div_cnt  <= 8'd0;
			bit_cnt  <= 6'd0;
		end else begin
			fin      <= 1'b0;
			adc_done <= fin;
			ad_conv  <= 1'b0;
			if (!busy) begin
				// single cycle conversion strobe
				if (adc_trig) begin
					busy    <= 1'b1;
					ad_conv <= 1'b1;
					div_cnt <= 8'd0;
					bit_cnt <= 6'd0;
				end
			end else if (!ad_conv) begin
				if (half_end) begin
					div_cnt <= 8'd0;
					spi_sck <= !spi_sck;
					if (spi_sck) begin
						// falling edge closes one clock
						if (last_clk) begin
							busy <= 1'b0;
							fin  <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 6'd1;
						end
					end
				end else begin
					div_cnt <= div_cnt + 8'd1;
				end
			end
		end
	end

	////////////////////////////////////////
	// frame shift and channel split
	////////////////////////////////////////

	// sample on the edge that raises sck
	always_ff @(posedge clk50mhz) begin
		if (half_end && !spi_sck)
			frame.raw <= {frame.raw[preamp_adc_pkg::ADC_FRAME_BITS-2:0], adc_out};
	end

	// filler bits dropped here
	// results move only with adc_done
	always_ff @(posedge clk50mhz) begin
		if (fin) begin
			adc_a <= frame.fld.ch_a;
			adc_b <= frame.fld.ch_b;
		end
	end

endmodule

`default_nettype wire

// File: verilog/preamp_adc_top.sv
`timescale 1ns/1ns
`default_nettype none

module preamp_adc_top (
	input  logic        clk50mhz,
	input  logic        arst_n,
	// shared serial bus
	output logic        spi_sck,
	output logic        spi_mosi,
	// preamp
	output logic        amp_cs,
	output logic        amp_shdn,
	input  logic        amp_dout,
	// adc
	output logic        ad_conv,
	input  logic        adc_out,
	// switches and leds
	input  logic [3:0]  sw,
	output logic [7:0]  led,
	// captured samples
	output logic [13:0] sample_a,
	output logic [13:0] sample_b,
	output logic        sample_valid
);

	// preamp handshake
	logic        amp_trig;
	logic [3:0]  amp_a;
	logic [3:0]  amp_b;
	logic        amp_done;
	// timer
	logic        cnt_en;
	logic [15:0] cnt_max;
	logic        adc_trig;
	// adc results
	logic        adc_done;
	logic [13:0] adc_a;
	logic [13:0] adc_b;
	// per device serial clocks
	logic        spi_sck_amp;
	logic        spi_sck_adc;

	capture_ctrl u_ctrl (
		.clk50mhz(clk50mhz), .arst_n(arst_n), .sw(sw),
		.amp_trig(amp_trig), .amp_a(amp_a), .amp_b(amp_b), .amp_done(amp_done),
		.cnt_en(cnt_en), .cnt_max(cnt_max),
		.adc_done(adc_done), .adc_a(adc_a), .adc_b(adc_b),
		.led(led), .sample_a(sample_a), .sample_b(sample_b), .sample_valid(sample_valid)
	);

	amp_gain_spi u_amp (
		.clk50mhz(clk50mhz), .arst_n(arst_n),
		.amp_trig(amp_trig), .amp_a(amp_a), .amp_b(amp_b), .amp_done(amp_done),
		.spi_sck(spi_sck_amp), .spi_mosi(spi_mosi),
		.amp_cs(amp_cs), .amp_shdn(amp_shdn), .amp_dout(amp_dout)
	);

	sample_timer u_timer (
		.clk50mhz(clk50mhz), .arst_n(arst_n),
		.cnt_en(cnt_en), .cnt_max(cnt_max), .cnt_trig(adc_trig)
	);

	adc_capture u_adc (
		.clk50mhz(clk50mhz), .arst_n(arst_n), .adc_trig(adc_trig),
		.spi_sck(spi_sck_adc), .ad_conv(ad_conv), .adc_out(adc_out),
		.adc_done(adc_done), .adc_a(adc_a), .adc_b(adc_b)
	);

	// both idle low, never active together
	assign spi_sck = spi_sck_amp | spi_sck_adc;

endmodule

`default_nettype wire

// File: verif/preamp_adc_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module preamp_adc_assertions (
	input logic clk50mhz,
	input logic arst_n,
	input logic spi_sck,
	input logic amp_cs,
	input logic ad_conv,
	input logic adc_done
);

	logic frame_active;

	// from the conversion strobe until the frame result
	always_ff @(posedge clk50mhz or negedge arst_n) begin
		if (!arst_n)
			frame_active <= 1'b0;
		else if (ad_conv)
			frame_active <= 1'b1;
		else if (adc_done)
			frame_active <= 1'b0;
	end

	// preamp deselected and no frame, so the shared clock stays put
	sck_quiet: assert property (@(posedge clk50mhz) disable iff (!arst_n)
		(amp_cs && $past(amp_cs) && !frame_active) |-> $stable(spi_sck))
		else $error("spi_sck toggled while the bus was idle");

	// strobe is a single cycle
	conv_pulse: assert property (@(posedge clk50mhz) disable iff (!arst_n)
		ad_conv |=> !ad_conv)
		else $error("ad_conv held for more than one cycle");

	// preamp stays deselected for the whole adc frame
	cs_in_frame: assert property (@(posedge clk50mhz) disable iff (!arst_n)
		(ad_conv || frame_active) |-> amp_cs)
		else $error("amp_cs low during an adc frame");

endmodule

bind preamp_adc_top preamp_adc_assertions u_assertions (
	.clk50mhz(clk50mhz),
	.arst_n(arst_n),
	.spi_sck(spi_sck),
	.amp_cs(amp_cs),
	.ad_conv(ad_conv),
	.adc_done(adc_done)
);

`default_nettype wire

// File: verif/preamp_adc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module preamp_adc_tb;

	localparam int NUM_CHANGES = 12;
	localparam int WORD_TIMEOUT = 2000;

	logic        clk50mhz;
	logic        arst_n;
	logic        amp_dout;
	logic        adc_out = 1'b0;
	logic [3:0]  sw;
	logic        spi_sck;
	logic        spi_mosi;
	logic        amp_cs;
	logic        amp_shdn;
	logic        ad_conv;
	logic [7:0]  led;
	logic [13:0] sample_a;
	logic [13:0] sample_b;
	logic        sample_valid;

	integer seed = 49;
	int     err_count = 0;
	int     timeout_count = 0;
	logic   timed_out = 1'b0;
	// expected preamp words and {ch_a, ch_b} pairs
	logic [7:0]  word_q[$];
	logic [27:0] samp_q[$];
	int     words_seen = 0;
	int     samples_seen = 0;
	int     cycle_cnt = 0;
	// bus edge tracking, sampled on falling clk
	logic   sck_q = 1'b0;
	logic   cs_q = 1'b1;
	logic [7:0] amp_shift = 8'd0;
	// adc device model
	preamp_adc_pkg::adc_frame_u adc_frame;
	logic [5:0] adc_bit = 6'd0;
	logic   adc_active = 1'b0;
	// ad_conv spacing
	logic   measure = 1'b0;
	logic   have_ref = 1'b0;
	int     last_conv = 0;
	int     exp_period = 0;

	preamp_adc_top u_dut (
		.clk50mhz(clk50mhz), .arst_n(arst_n),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi),
		.amp_cs(amp_cs), .amp_shdn(amp_shdn), .amp_dout(amp_dout),
		.ad_conv(ad_conv), .adc_out(adc_out),
		.sw(sw), .led(led),
		.sample_a(sample_a), .sample_b(sample_b), .sample_valid(sample_valid)
	);

	initial begin
		clk50mhz = 1'b0;
		forever #5 clk50mhz = ~clk50mhz;
	end

	////////////////////////////////////////
	// reference rules
	////////////////////////////////////////

	// gain code is the switch index plus one, same code in both nibbles
	function automatic logic [7:0] gain_word(input logic [1:0] sel);
		logic [3:0] code;
		code = {2'b00, sel} + 4'd1;
		return {code, code};
	endfunction

	// 200 cycles, doubling per step
	function automatic int sample_period(input logic [1:0] sel);
		return 200 << sel;
	endfunction

	task automatic log_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		err_count++;
		$display("[FAIL] %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
	endtask

	task automatic log_violation(input string what);
		err_count++;
		$display("[FAIL] %0t: %s", $time, what);
	endtask

	task automatic check_word(input logic [7:0] got);
		logic [7:0] exp;
		words_seen++;
		if (word_q.size() == 0) begin
			log_violation("preamp received a word with no gain change pending");
		end else begin
			exp = word_q.pop_front();
			assert (got == exp) else log_mismatch("preamp word", 32'(got), 32'(exp));
		end
	endtask

	task automatic check_sample();
		logic [27:0] exp;
		samples_seen++;
		if (samp_q.size() == 0) begin
			log_violation("sample_valid without a frame sent by the adc model");
		end else begin
			exp = samp_q.pop_front();
			assert (sample_a == exp[27:14])
				else log_mismatch("sample_a", 32'(sample_a), 32'(exp[27:14]));
			assert (sample_b == exp[13:0])
				else log_mismatch("sample_b", 32'(sample_b), 32'(exp[13:0]));
			assert (led == exp[27:20])
				else log_mismatch("led", 32'(led), 32'(exp[27:20]));
		end
	endtask

	////////////////////////////////////////
	// device models and monitors
	////////////////////////////////////////

	always @(negedge clk50mhz) begin
		if (arst_n) begin
			cycle_cnt = cycle_cnt + 1;
			if (!measure)
				have_ref = 1'b0;
			// preamp shifts on sck rise while selected
			if (!amp_cs && spi_sck && !sck_q)
				amp_shift = {amp_shift[6:0], spi_mosi};
			// word complete on cs release
			if (amp_cs && !cs_q)
				check_word(amp_shift);
			if (ad_conv) begin
				assert (words_seen > 0)
					else log_violation("ad_conv came before the first preamp word");
				assert (!adc_active)
					else log_violation("ad_conv came during an open adc frame");
				// fresh samples, random filler around them
				adc_frame.raw = 34'd0;
				adc_frame.fld.lead = 2'($random(seed));
				adc_frame.fld.ch_a = 14'($random(seed));
				adc_frame.fld.mid = 2'($random(seed));
				adc_frame.fld.ch_b = 14'($random(seed));
				adc_frame.fld.tail = 2'($random(seed));
				samp_q.push_back({adc_frame.fld.ch_a, adc_frame.fld.ch_b});
				adc_bit = 6'd33;
				adc_out = adc_frame.raw[adc_bit];
				adc_active = 1'b1;
				if (have_ref)
					assert (cycle_cnt - last_conv == exp_period)
						else log_mismatch("ad_conv spacing", 32'(cycle_cnt - last_conv),
							32'(exp_period));
				last_conv = cycle_cnt;
				have_ref = measure;
			end else if (adc_active && !spi_sck && sck_q) begin
				// next bit after each falling sck
				if (adc_bit == 6'd0) begin
					adc_active = 1'b0;
					adc_out = 1'b0;
				end else begin
					adc_bit = adc_bit - 6'd1;
					adc_out = adc_frame.raw[adc_bit];
				end
			end
			// preamp and adc must not share the clock at once
			assert (amp_cs || !adc_active)
				else log_violation("preamp transfer overlaps an adc frame");
			// preamp kept powered
			assert (amp_shdn == 1'b0)
				else log_mismatch("amp_shdn", 32'(amp_shdn), 32'd0);
			if (sample_valid)
				check_sample();
			sck_q = spi_sck;
			cs_q = amp_cs;
		end
	end

	////////////////////////////////////////
	// waits, each with its own limit
	////////////////////////////////////////

	task automatic wait_words(input int count);
		int t;
		t = 0;
		while (!timed_out && words_seen < count && t < WORD_TIMEOUT) begin
			@(negedge clk50mhz);
			t++;
		end
		if (!timed_out && words_seen < count) begin
			timed_out = 1'b1;
			timeout_count++;
			$display("timeout at %0t: preamp word %0d never arrived", $time, count);
		end
	endtask

	task automatic wait_samples(input int n);
		int t;
		int target;
		int limit;
		t = 0;
		target = samples_seen + n;
		limit = n * 1700 + 400;
		while (!timed_out && samples_seen < target && t < limit) begin
			@(negedge clk50mhz);
			t++;
		end
		if (!timed_out && samples_seen < target) begin
			timed_out = 1'b1;
			timeout_count++;
			$display("timeout at %0t: samples stopped arriving", $time);
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin : stimulus
		logic [3:0] next_sw;
		int exp_words;
		int i;
		arst_n = 1'b0;
		amp_dout = 1'b0;
		sw = 4'($random(seed));
		// first programming after reset
		word_q.push_back(gain_word(sw[1:0]));
		exp_words = 1;
		exp_period = sample_period(sw[3:2]);
		repeat (5) @(negedge clk50mhz);
		arst_n = 1'b1;
		wait_words(exp_words);
		// first sample runs off a fresh timer start
		wait_samples(2);
		measure = 1'b1;
		wait_samples(3);
		for (i = 0; i < NUM_CHANGES && !timed_out; i++) begin
			next_sw = 4'($random(seed));
			measure = 1'b0;
			if (next_sw[1:0] != sw[1:0]) begin
				word_q.push_back(gain_word(next_sw[1:0]));
				exp_words++;
			end
			exp_period = sample_period(next_sw[3:2]);
			sw = next_sw;
			wait_words(exp_words);
			// one frame may still be in flight from the old rate
			wait_samples(2);
			measure = 1'b1;
			wait_samples(3);
		end
		$display("errors: %0d, timeouts: %0d, samples: %0d, preamp words: %0d",
			err_count, timeout_count, samples_seen, words_seen);
		if (err_count == 0 && timeout_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: preamp_adc.f
verilog/preamp_adc_pkg.sv
verilog/capture_ctrl.sv
verilog/amp_gain_spi.sv
verilog/sample_timer.sv
verilog/adc_capture.sv
verilog/preamp_adc_top.sv
verif/preamp_adc_assertions.sv
verif/preamp_adc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the preamp_adc testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=preamp_adc_sim
LOG=sim.log

verilator --binary --timing --assert \
	--top-module preamp_adc_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN" \
	-f preamp_adc.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi

echo "simulation finished without failures"
exit 0
